// File: logic/commandRegisters.sv
`timescale 1ns/1ps

module commandRegisters
(
	input  logic OSC_FPGA,
	input  logic reset_i,
	input  logic PSEL_i,
	input  logic PENABLE_i,
	input  logic PWRITE_i,
	input  logic [hostBusPkg::busAddrWidth-1:0] PADDR_i,
	input  logic [hostBusPkg::busDataWidth-1:0] PWDATA_i,
	input  logic [motionPkg::encoderCountWidth-1:0] encoderLeftCount_i,
	input  logic [motionPkg::encoderCountWidth-1:0] encoderRightCount_i,
	output logic [hostBusPkg::busDataWidth-1:0] PRDATA_o,
	output logic motorOverride_o,
	output logic cameraOverride_o,
	output logic alarm_o,
	output logic [motionPkg::percentWidth-1:0] leftMotorPercent_o,
	output logic [motionPkg::percentWidth-1:0] rightMotorPercent_o,
	output logic [motionPkg::percentWidth-1:0] camPanPercent_o,
	output logic [motionPkg::percentWidth-1:0] camTiltPercent_o
);
	import hostBusPkg::*;
	import motionPkg::*;

	commandWordT writeWord;
	commandWordT controlView;
	commandWordT setpointView;
	logic writeAccess;
	logic setpointWrite;
	logic [widthTicksWidth-1:0] ticksSinceCommand;

	// --------------------
	// Write decode
	// --------------------
	// Same bus word, read through whichever view the address selects
	assign writeWord = PWDATA_i;

	// Zero wait states, so the access phase is the commit cycle
	assign writeAccess = PSEL_i & PENABLE_i & PWRITE_i;
	assign setpointWrite = writeAccess && (PADDR_i == addrSetpoints);

	always_ff @(posedge OSC_FPGA)
	begin
		if (reset_i)
		begin
			// RC receiver in charge after reset
			motorOverride_o <= 1'b0;
			cameraOverride_o <= 1'b0;
			alarm_o <= 1'b0;
			leftMotorPercent_o <= percentCenter;
			rightMotorPercent_o <= percentCenter;
			camPanPercent_o <= percentCenter;
			camTiltPercent_o <= percentCenter;
		end
		else if (writeAccess)
		begin
			case (PADDR_i)
				addrControl:
				begin
					motorOverride_o <= writeWord.control.motorOverride;
					cameraOverride_o <= writeWord.control.cameraOverride;
					alarm_o <= writeWord.control.alarm;
				end
				addrSetpoints:
				begin
					leftMotorPercent_o <= writeWord.setpoint.leftMotor;
					rightMotorPercent_o <= writeWord.setpoint.rightMotor;
					camPanPercent_o <= writeWord.setpoint.camPan;
					camTiltPercent_o <= writeWord.setpoint.camTilt;
				end
				// Read-only and unmapped addresses drop the write
				default: ;
			endcase
		end
	end

	// Time since the last setpoint write
	// host divides encoder deltas by it to get wheel speed
	always_ff @(posedge OSC_FPGA)
	begin
		if (reset_i || setpointWrite)
			ticksSinceCommand <= '0;
		else
			ticksSinceCommand <= ticksSinceCommand + 1'b1;
	end

	// --------------------
	// Read back
	// --------------------
	always_comb
	begin
		controlView = '0;
		controlView.control.motorOverride = motorOverride_o;
		controlView.control.cameraOverride = cameraOverride_o;
		controlView.control.alarm = alarm_o;
		setpointView.setpoint.leftMotor = leftMotorPercent_o;
		setpointView.setpoint.rightMotor = rightMotorPercent_o;
		setpointView.setpoint.camPan = camPanPercent_o;
		setpointView.setpoint.camTilt = camTiltPercent_o;
	end

	// Plain address mux, valid whenever the access phase samples it
	always_comb
	begin
		case (PADDR_i)
			addrControl: PRDATA_o = controlView;
			addrSetpoints: PRDATA_o = setpointView;
			addrEncoderLeft: PRDATA_o = encoderLeftCount_i;
			addrEncoderRight: PRDATA_o = encoderRightCount_i;
			addrTicksSinceCommand: PRDATA_o = ticksSinceCommand;
			addrIdentity: PRDATA_o = identityWord;
			default: PRDATA_o = '0;
		endcase
	end

endmodule

// File: logic/hostBusPkg.sv
package hostBusPkg;

	// --------------------
	// APB bus geometry
	// --------------------
	localparam int busAddrWidth = 4;
	localparam int busDataWidth = 32;

	// Word addresses seen by the host
	localparam logic [busAddrWidth-1:0] addrControl           = 4'd0;
	localparam logic [busAddrWidth-1:0] addrSetpoints         = 4'd1;
	localparam logic [busAddrWidth-1:0] addrEncoderLeft       = 4'd2;
	localparam logic [busAddrWidth-1:0] addrEncoderRight      = 4'd3;
	localparam logic [busAddrWidth-1:0] addrTicksSinceCommand = 4'd4;
	localparam logic [busAddrWidth-1:0] addrIdentity          = 4'd5;

	// Fixed value so host software can recognise the board
	localparam logic [busDataWidth-1:0] identityWord = 32'hBA5EBA11;

	// --------------------
	// Command word views
	// --------------------
	typedef struct packed
	{
		logic [busDataWidth-4:0] reserved;
		logic alarm;
		logic cameraOverride;
		logic motorOverride;
	} controlViewT;

	// Byte order as host software packs its setpoint block
	typedef struct packed
	{
		logic [7:0] camTilt;
		logic [7:0] camPan;
		logic [7:0] leftMotor;
		logic [7:0] rightMotor;
	} setpointViewT;

	typedef union packed
	{
		controlViewT control;
		setpointViewT setpoint;
	} commandWordT;

endpackage

// File: logic/motionPkg.sv
package motionPkg;

	// --------------------
	// Setpoint encoding
	// --------------------
	localparam int percentWidth = 8;

	// 0 is full reverse, 200 full forward
	localparam logic [percentWidth-1:0] percentMax    = 8'd200;
	// Motors at rest, camera centred
	localparam logic [percentWidth-1:0] percentCenter = 8'd100;

	// --------------------
	// RC pulse timing
	// --------------------
	// Shortest legal RC pulse, 1.0 ms
	localparam int unsigned pulseLowLimitUs = 1000;

	// 200 steps of 5 us span the extra 1.0 ms of throw
	localparam int unsigned pulseStepUs = 5;

	// 22 ms frame, what the motor drivers expect
	localparam int unsigned frameLengthUs = 22000;

	// Width of all tick counters in the design
	localparam int widthTicksWidth = 32;

	// --------------------
	// Encoder counts
	// --------------------
	localparam int encoderCountWidth = 32;

	// Start at mid scale
	// keeps wheel travel in either direction well clear of a wrap
	localparam logic [encoderCountWidth-1:0] encoderStartCount = 32'h80000000;

endpackage

// File: logic/quadratureCounter.sv
`timescale 1ns/1ps

module quadratureCounter
(
	input  logic OSC_FPGA,
	input  logic reset_i,
	input  logic encoderA_i,
	input  logic encoderB_i,
	output logic [motionPkg::encoderCountWidth-1:0] count_o,
	output logic direction_o
);
	import motionPkg::*;

	logic [1:0] aSync;
	logic [1:0] bSync;
	logic [1:0] currState;
	logic [1:0] prevState;
	logic stepValid;
	logic stepForward;

	// Gray state as {A, B} after the synchronizer
	assign currState = {aSync[1], bSync[1]};

	// Exactly one phase moved
	// no move or a two-bit jump both fail this
	assign stepValid = ^(currState ^ prevState);

	// Forward order 00 10 11 01, A leading B
	assign stepForward = prevState[0] ^ currState[1];

	always_ff @(posedge OSC_FPGA)
	begin
		if (reset_i)
		begin
			aSync <= '0;
			bSync <= '0;
			prevState <= '0;
			count_o <= encoderStartCount;
			direction_o <= 1'b0;
		end
		else
		begin
			// Two flops per phase, encoder lines are asynchronous
			aSync <= {aSync[0], encoderA_i};
			bSync <= {bSync[0], encoderB_i};
			prevState <= currState;
			if (stepValid)
			begin
				count_o <= stepForward ? count_o + 1'b1 : count_o - 1'b1;
				direction_o <= stepForward;
			end
		end
	end

endmodule

// File: logic/rcServoChannel.sv
`timescale 1ns/1ps

module rcServoChannel
#(
	parameter int unsigned ticksPerMicrosecond = 50
)
(
	input  logic OSC_FPGA,
	input  logic reset_i,
	input  logic [motionPkg::percentWidth-1:0] percent_i,
	input  logic override_i,
	input  logic rcPassthrough_i,
	output logic ppm_o
);
	import motionPkg::*;

	// Timing constants scaled to clock ticks
	localparam logic [widthTicksWidth-1:0] lowLimitTicks =
		widthTicksWidth'(pulseLowLimitUs * ticksPerMicrosecond);
	localparam logic [widthTicksWidth-1:0] stepTicks =
		widthTicksWidth'(pulseStepUs * ticksPerMicrosecond);
	localparam logic [widthTicksWidth-1:0] frameTicks =
		widthTicksWidth'(frameLengthUs * ticksPerMicrosecond);
	localparam logic [widthTicksWidth-1:0] centerTicks =
		lowLimitTicks + stepTicks * widthTicksWidth'(percentCenter);

	logic [percentWidth-1:0] clampedPercent;
	logic [widthTicksWidth-1:0] targetWidth;
	logic [widthTicksWidth-1:0] activeWidth;
	logic [widthTicksWidth-1:0] frameCount;
	logic frameEnd;
	logic pulseGen;

	// --------------------
	// Percent to width
	// --------------------
	// Anything above full throw is held at full throw
	assign clampedPercent = (percent_i > percentMax) ? percentMax : percent_i;

	always_ff @(posedge OSC_FPGA)
	begin
		if (reset_i)
			targetWidth <= centerTicks;
		else
			targetWidth <= lowLimitTicks + stepTicks * widthTicksWidth'(clampedPercent);
	end

	// --------------------
	// Frame timer
	// --------------------
	assign frameEnd = (frameCount == frameTicks - 1'b1);

	// Width only changes on a frame boundary so no pulse is ever cut short
	always_ff @(posedge OSC_FPGA)
	begin
		if (reset_i)
		begin
			frameCount <= '0;
			activeWidth <= centerTicks;
		end
		else if (frameEnd)
		begin
			frameCount <= '0;
			activeWidth <= targetWidth;
		end
		else
			frameCount <= frameCount + 1'b1;
	end

	// High from frame start for activeWidth ticks
	assign pulseGen = (frameCount < activeWidth);

	// Host pulse or straight RC receiver
	assign ppm_o = override_i ? pulseGen : rcPassthrough_i;

endmodule

// File: logic/robotIoController.sv
`timescale 1ns/1ps

module robotIoController
#(
	parameter int unsigned ticksPerMicrosecond = 50
)
(
	input  logic OSC_FPGA,
	input  logic reset_i,

	// Host APB port
	input  logic PSEL_i,
	input  logic PENABLE_i,
	input  logic PWRITE_i,
	input  logic [hostBusPkg::busAddrWidth-1:0] PADDR_i,
	input  logic [hostBusPkg::busDataWidth-1:0] PWDATA_i,
	output logic [hostBusPkg::busDataWidth-1:0] PRDATA_o,

	// RC receiver channels
	input  logic rcLeftMotor_i,
	input  logic rcRightMotor_i,
	input  logic rcCamPan_i,
	input  logic rcCamTilt_i,

	// Wheel encoders
	input  logic encoderLeftA_i,
	input  logic encoderLeftB_i,
	input  logic encoderRightA_i,
	input  logic encoderRightB_i,

	// Servo and motor driver outputs
	output logic motorLeftPpm_o,
	output logic motorRightPpm_o,
	output logic camPanPpm_o,
	output logic camTiltPpm_o,
	output logic alarm_o
);
	import motionPkg::*;

	logic motorOverride;
	logic cameraOverride;
	logic [percentWidth-1:0] leftMotorPercent;
	logic [percentWidth-1:0] rightMotorPercent;
	logic [percentWidth-1:0] camPanPercent;
	logic [percentWidth-1:0] camTiltPercent;
	logic [encoderCountWidth-1:0] encoderLeftCount;
	logic [encoderCountWidth-1:0] encoderRightCount;

	// --------------------
	// Host registers
	// --------------------
	commandRegisters commandRegs
	(
		.OSC_FPGA(OSC_FPGA),
		.reset_i(reset_i),
		.PSEL_i(PSEL_i),
		.PENABLE_i(PENABLE_i),
		.PWRITE_i(PWRITE_i),
		.PADDR_i(PADDR_i),
		.PWDATA_i(PWDATA_i),
		.encoderLeftCount_i(encoderLeftCount),
		.encoderRightCount_i(encoderRightCount),
		.PRDATA_o(PRDATA_o),
		.motorOverride_o(motorOverride),
		.cameraOverride_o(cameraOverride),
		.alarm_o(alarm_o),
		.leftMotorPercent_o(leftMotorPercent),
		.rightMotorPercent_o(rightMotorPercent),
		.camPanPercent_o(camPanPercent),
		.camTiltPercent_o(camTiltPercent)
	);

	// --------------------
	// Servo channels
	// --------------------
	// Motors share one override, camera axes the other
	rcServoChannel #(.ticksPerMicrosecond(ticksPerMicrosecond)) leftMotorChannel
	(
		.OSC_FPGA(OSC_FPGA),
		.reset_i(reset_i),
		.percent_i(leftMotorPercent),
		.override_i(motorOverride),
		.rcPassthrough_i(rcLeftMotor_i),
		.ppm_o(motorLeftPpm_o)
	);

	rcServoChannel #(.ticksPerMicrosecond(ticksPerMicrosecond)) rightMotorChannel
	(
		.OSC_FPGA(OSC_FPGA),
		.reset_i(reset_i),
		.percent_i(rightMotorPercent),
		.override_i(motorOverride),
		.rcPassthrough_i(rcRightMotor_i),
		.ppm_o(motorRightPpm_o)
	);

	rcServoChannel #(.ticksPerMicrosecond(ticksPerMicrosecond)) camPanChannel
	(
		.OSC_FPGA(OSC_FPGA),
		.reset_i(reset_i),
		.percent_i(camPanPercent),
		.override_i(cameraOverride),
		.rcPassthrough_i(rcCamPan_i),
		.ppm_o(camPanPpm_o)
	);

	rcServoChannel #(.ticksPerMicrosecond(ticksPerMicrosecond)) camTiltChannel
	(
		.OSC_FPGA(OSC_FPGA),
		.reset_i(reset_i),
		.percent_i(camTiltPercent),
		.override_i(cameraOverride),
		.rcPassthrough_i(rcCamTilt_i),
		.ppm_o(camTiltPpm_o)
	);

	// --------------------
	// Encoder counters
	// --------------------
	// Direction only for probing on the board
	quadratureCounter leftEncoder
	(
		.OSC_FPGA(OSC_FPGA),
		.reset_i(reset_i),
		.encoderA_i(encoderLeftA_i),
		.encoderB_i(encoderLeftB_i),
		.count_o(encoderLeftCount),
		.direction_o()
	);

	quadratureCounter rightEncoder
	(
		.OSC_FPGA(OSC_FPGA),
		.reset_i(reset_i),
		.encoderA_i(encoderRightA_i),
		.encoderB_i(encoderRightB_i),
		.count_o(encoderRightCount),
		.direction_o()
	);

endmodule

// File: robotIoController.f
logic/hostBusPkg.sv
logic/motionPkg.sv
logic/commandRegisters.sv
logic/rcServoChannel.sv
logic/quadratureCounter.sv
logic/robotIoController.sv
verification/robotIoControllerTb.sv

// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module robotIoControllerTb -f robotIoController.f \
	|| { echo "Verilator build failed"; exit 1; }
output=$(./obj_dir/VrobotIoControllerTb 2>&1)
echo "$output"
echo "$output" | grep -q "All tests passed!" \
	&& echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }

// File: verification/robotIoControllerTb.sv
`timescale 1ns/1ps

module robotIoControllerTb;
	import hostBusPkg::*;
	import motionPkg::*;

	localparam int unsigned tbTicksPerMicrosecond = 1;
	localparam real clockPeriodNs = 100.0;
	localparam real driveDelayNs = 10.0;
	localparam int stepLimit = 64;
	localparam int unsigned frameTicks = frameLengthUs * tbTicksPerMicrosecond;

	// Operation codes, first column of the data file
	localparam logic [31:0] opWrite       = 32'h01;
	localparam logic [31:0] opRead        = 32'h02;
	localparam logic [31:0] opForward     = 32'h03;
	localparam logic [31:0] opReverse     = 32'h04;
	localparam logic [31:0] opIllegal     = 32'h05;
	localparam logic [31:0] opPulse       = 32'h06;
	localparam logic [31:0] opPassthrough = 32'h07;
	localparam logic [31:0] opAlarm       = 32'h08;
	localparam logic [31:0] opWait        = 32'h09;
	localparam logic [31:0] opEnd         = 32'hFF;

	logic OSC_FPGA;
	logic reset_i;
	logic PSEL_i;
	logic PENABLE_i;
	logic PWRITE_i;
	logic [busAddrWidth-1:0] PADDR_i;
	logic [busDataWidth-1:0] PWDATA_i;
	logic [busDataWidth-1:0] PRDATA_o;
	logic alarm_o;

	// Bit order left motor, right motor, pan, tilt
	logic [3:0] rcInputs;
	logic [3:0] ppmOutputs;

	// Encoder phases as {A, B}
	logic [1:0] leftPhase;
	logic [1:0] rightPhase;
	int encoderPos [0:1];

	logic [31:0] stepMem [0:stepLimit*4-1];
	int stepCount;
	logic stepsLoaded;

	robotIoController #(.ticksPerMicrosecond(tbTicksPerMicrosecond)) i_dut
	(
		.OSC_FPGA(OSC_FPGA),
		.reset_i(reset_i),
		.PSEL_i(PSEL_i),
		.PENABLE_i(PENABLE_i),
		.PWRITE_i(PWRITE_i),
		.PADDR_i(PADDR_i),
		.PWDATA_i(PWDATA_i),
		.PRDATA_o(PRDATA_o),
		.rcLeftMotor_i(rcInputs[0]),
		.rcRightMotor_i(rcInputs[1]),
		.rcCamPan_i(rcInputs[2]),
		.rcCamTilt_i(rcInputs[3]),
		.encoderLeftA_i(leftPhase[1]),
		.encoderLeftB_i(leftPhase[0]),
		.encoderRightA_i(rightPhase[1]),
		.encoderRightB_i(rightPhase[0]),
		.motorLeftPpm_o(ppmOutputs[0]),
		.motorRightPpm_o(ppmOutputs[1]),
		.camPanPpm_o(ppmOutputs[2]),
		.camTiltPpm_o(ppmOutputs[3]),
		.alarm_o(alarm_o)
	);

	initial
	begin
		OSC_FPGA = 1'b0;
		forever
			#(clockPeriodNs / 2.0) OSC_FPGA = ~OSC_FPGA;
	end

	// --------------------
	// Helpers
	// --------------------
	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stopRun($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected));
	endtask

	// Inputs move a little after the rising edge
	task automatic nextCycle();
		@(posedge OSC_FPGA);
		#(driveDelayNs);
	endtask

	function automatic string channelName(input int channel);
		case (channel)
			0: return "motorLeftPpm_o";
			1: return "motorRightPpm_o";
			2: return "camPanPpm_o";
			default: return "camTiltPpm_o";
		endcase
	endfunction

	// Forward order 00 10 11 01
	function automatic logic [1:0] grayCode(input int pos);
		case (pos)
			0: return 2'b00;
			1: return 2'b10;
			2: return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	// --------------------
	// Bus and pin tasks
	// --------------------
	task automatic apbWrite(input logic [busAddrWidth-1:0] addr, input logic [31:0] data);
		PSEL_i = 1'b1;
		PENABLE_i = 1'b0;
		PWRITE_i = 1'b1;
		PADDR_i = addr;
		PWDATA_i = data;
		nextCycle();
		PENABLE_i = 1'b1;
		// Write lands on this edge
		nextCycle();
		PSEL_i = 1'b0;
		PENABLE_i = 1'b0;
		PWRITE_i = 1'b0;
	endtask

	task automatic apbRead(input logic [busAddrWidth-1:0] addr, input logic [31:0] expected);
		PSEL_i = 1'b1;
		PENABLE_i = 1'b0;
		PWRITE_i = 1'b0;
		PADDR_i = addr;
		nextCycle();
		PENABLE_i = 1'b1;
		// Mid access phase, PRDATA settled
		@(negedge OSC_FPGA);
		compareValue($sformatf("PRDATA_o at address %0d", addr), PRDATA_o, expected);
		nextCycle();
		PSEL_i = 1'b0;
		PENABLE_i = 1'b0;
	endtask

	// One Gray move, held long enough to reach the count register
	task automatic stepEncoder(input int encoder, input int delta);
		encoderPos[encoder] = (encoderPos[encoder] + delta + 4) % 4;
		if (encoder == 0)
			leftPhase = grayCode(encoderPos[encoder]);
		else
			rightPhase = grayCode(encoderPos[encoder]);
		repeat (3) nextCycle();
	endtask

	task automatic waitPulseStart(input int channel);
		logic previous;
		@(negedge OSC_FPGA);
		previous = ppmOutputs[channel];
		@(negedge OSC_FPGA);
		while (previous || !ppmOutputs[channel])
		begin
			previous = ppmOutputs[channel];
			@(negedge OSC_FPGA);
		end
	endtask

	// First rise may come from the override switch, second one is a true frame start
	task automatic measurePulse(input int channel, input logic [31:0] expectedWidth);
		int highCycles;
		int lowCycles;
		waitPulseStart(channel);
		waitPulseStart(channel);
		highCycles = 1;
		lowCycles = 0;
		@(negedge OSC_FPGA);
		while (ppmOutputs[channel])
		begin
			highCycles++;
			@(negedge OSC_FPGA);
		end
		while (!ppmOutputs[channel])
		begin
			lowCycles++;
			@(negedge OSC_FPGA);
		end
		compareValue({channelName(channel), " high cycles"}, highCycles, expectedWidth);
		compareValue({channelName(channel), " frame cycles"}, highCycles + lowCycles, frameTicks);
		nextCycle();
	endtask

	task automatic checkPassthrough(input logic [3:0] pattern, input logic [31:0] expected);
		rcInputs = pattern;
		@(negedge OSC_FPGA);
		compareValue("{camTiltPpm_o, camPanPpm_o, motorRightPpm_o, motorLeftPpm_o}",
			{28'h0, ppmOutputs}, expected);
		nextCycle();
	endtask

	task automatic checkAlarm(input logic [31:0] expected);
		@(negedge OSC_FPGA);
		compareValue("alarm_o", {31'h0, alarm_o}, expected);
		nextCycle();
	endtask

	// --------------------
	// Sequence
	// --------------------
	initial
	begin
		logic [31:0] op;
		logic [31:0] arg;
		logic [31:0] data;
		logic [31:0] expected;
		stepsLoaded = 1'b0;
		reset_i = 1'b1;
		PSEL_i = 1'b0;
		PENABLE_i = 1'b0;
		PWRITE_i = 1'b0;
		PADDR_i = '0;
		PWDATA_i = '0;
		rcInputs = '0;
		leftPhase = 2'b00;
		rightPhase = 2'b00;
		encoderPos[0] = 0;
		encoderPos[1] = 0;

		$readmemh("verification/robotIoInput.txt", stepMem);
		stepCount = 0;
		while (stepCount < stepLimit && stepMem[stepCount*4] !== opEnd)
			stepCount++;
		if (stepCount == stepLimit)
			stopRun("Data file has no end marker within the step limit");
		stepsLoaded = 1'b1;

		repeat (10) @(posedge OSC_FPGA);
		#(driveDelayNs);
		reset_i = 1'b0;

		for (int step = 0; step < stepCount; step++)
		begin
			op = stepMem[step*4];
			arg = stepMem[step*4+1];
			data = stepMem[step*4+2];
			expected = stepMem[step*4+3];
			case (op)
				opWrite: apbWrite(arg[busAddrWidth-1:0], data);
				opRead: apbRead(arg[busAddrWidth-1:0], expected);
				opForward: repeat (data) stepEncoder(int'(arg[0]), 1);
				opReverse: repeat (data) stepEncoder(int'(arg[0]), -1);
				opIllegal: stepEncoder(int'(arg[0]), 2);
				opPulse: measurePulse(int'(arg[1:0]), expected);
				opPassthrough: checkPassthrough(data[3:0], expected);
				opAlarm: checkAlarm(expected);
				opWait: repeat (data) nextCycle();
				default: stopRun($sformatf("Unknown operation code %0h in step %0d", op, step));
			endcase
		end

		$display("All tests passed!");
		$finish;
	end

	// Pulse steps run about three frames each, the other steps only a few cycles
	initial
	begin
		real limitNs;
		wait (stepsLoaded === 1'b1);
		limitNs = (stepCount * 2.0 * frameTicks + 1000.0) * clockPeriodNs;
		#(limitNs);
		stopRun("Watchdog expired before the test sequence finished");
	end

endmodule

// File: verification/robotIoInput.txt
// Columns: op arg data expected, all hex. op 1 write, 2 read, 3 enc fwd, 4 enc rev, 5 illegal jump
// op 6 pulse width, 7 pass-through, 8 alarm, 9 wait cycles, FF end. enc 0 left 1 right, channel 0..3
02 0 0 00000000
02 1 0 64646464
02 2 0 80000000
02 3 0 80000000
02 5 0 BA5EBA11
08 0 0 00000000
07 0 5 00000005
07 0 A 0000000A
01 0 4 00000000
08 0 0 00000001
07 0 C 0000000C
07 0 3 00000003
01 1 9600FA32 00000000
02 1 0 9600FA32
01 0 7 00000000
06 0 0 000007D0
06 1 0 000004E2
06 2 0 000003E8
06 3 0 000006D6
03 0 5 00000000
05 0 0 00000000
03 0 2 00000000
04 1 3 00000000
05 1 0 00000000
02 2 0 80000007
02 3 0 7FFFFFFD
01 1 64646464 00000000
09 0 8 00000000
02 4 0 00000009
FF 0 0 00000000
